/* tape_deck_pkg.sv */
package tape_deck_pkg;

    // ------------------------------------------------------------------------
    // Register port
    // ------------------------------------------------------------------------
    typedef logic [7:0] reg_addr_t;

    localparam reg_addr_t REG_SRAM_ADDR     = 8'hFB;  // Shifts in one address byte
    localparam reg_addr_t REG_SRAM_DATA_INC = 8'hFC;  // Data, address advances
    localparam reg_addr_t REG_SRAM_DATA     = 8'hFD;  // Data, address holds

    // ------------------------------------------------------------------------
    // Tape image format
    // ------------------------------------------------------------------------
    localparam logic [7:0] TAG_PULSE = 8'h50;
    localparam logic [7:0] TAG_PAUSE = 8'h57;
    localparam logic [7:0] TAG_STOP  = 8'h53;

    // Pulse words: flag bit on top, fifteen value bits below
    localparam int WORD_W = 16;

    typedef logic [31:0] dur_t;  // T-states

    typedef enum logic [3:0] {
        ST_IDLE,        // Fully stopped, next play rewinds
        ST_TAG,
        ST_LEN,
        ST_SKIP,        // Drops the rest of a block body
        ST_PAUSE_DUR,
        ST_PAUSE_HOLD,
        ST_PULSE_W0,    // Count or duration word
        ST_PULSE_DUR,
        ST_PULSE_EXT,   // Low half of a 31-bit duration
        ST_PULSE_HOLD
    } player_state_e;

endpackage

/* sram_bus_if.sv */
`timescale 1ns/1ps

// One requester's channel into the shared byte memory
interface sram_bus_if #(
    parameter int ADDR_W = 21
);
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              gnt;     // One cycle per accepted access
    logic              rvalid;  // Exactly one cycle after a read grant
    logic [7:0]        rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

/* pzx_stream_if.sv */
`timescale 1ns/1ps

// Byte stream from the fetcher to the player
interface pzx_stream_if #(
    parameter int ADDR_W = 21
);
    logic              valid;    // Buffer head holds a byte
    logic [7:0]        data;
    logic              take;     // Sink pops the head
    logic              restart;  // Flush and move the fetch pointer
    logic [ADDR_W-1:0] restart_addr;

    modport source (
        output valid, data,
        input  take, restart, restart_addr
    );

    modport sink (
        input  valid, data,
        output take, restart, restart_addr
    );

endinterface

/* sram_store.sv */
`timescale 1ns/1ps

module sram_store #(
    parameter int ADDR_W = 21
) (
    input  logic clk,
    sram_bus_if.arbiter mem
);

    logic [7:0] ram [2**ADDR_W];

    // Single port, so every request is taken at once
    assign mem.gnt = mem.req;

    always_ff @(posedge clk) begin
        if (mem.req && mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
        mem.rdata  <= ram[mem.addr];      // Read-first
        mem.rvalid <= mem.req && !mem.we;
    end

endmodule

/* sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter #(
    parameter int ADDR_W = 21
) (
    input  logic clk,
    input  logic rst_n,
    sram_bus_if.arbiter   cpu,
    sram_bus_if.arbiter   tape,
    sram_bus_if.requester mem
);

    logic              last_tape;  // Last winner was the tape channel
    logic              rsp_tape;   // Read returning this cycle belongs to tape
    logic              pick_tape;
    logic [ADDR_W-1:0] win_addr;

    // Alternate only on contention
    assign pick_tape = (cpu.req && tape.req) ? !last_tape : tape.req;

    always_comb begin
        if (pick_tape) begin
            win_addr  = tape.addr;
            mem.we    = tape.we;
            mem.wdata = tape.wdata;
        end else begin
            win_addr  = cpu.addr;
            mem.we    = cpu.we;
            mem.wdata = cpu.wdata;
        end
    end

    assign mem.req  = cpu.req || tape.req;
    assign mem.addr = win_addr;

    assign cpu.gnt  = mem.gnt && cpu.req && !pick_tape;
    assign tape.gnt = mem.gnt && tape.req && pick_tape;

    assign cpu.rvalid  = mem.rvalid && !rsp_tape;
    assign tape.rvalid = mem.rvalid && rsp_tape;
    assign cpu.rdata   = mem.rdata;
    assign tape.rdata  = mem.rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_tape <= 1'b1;  // Register port wins first
            rsp_tape  <= 1'b0;
        end else begin
            if (mem.gnt) begin
                last_tape <= pick_tape;
            end
            rsp_tape <= pick_tape;
        end
    end

    // A request that loses once wins the next cycle
    a_cpu_served: assert property (@(posedge clk) disable iff (!rst_n)
        cpu.req && !cpu.gnt |=> cpu.gnt)
        else $error("register port request starved");

    a_tape_served: assert property (@(posedge clk) disable iff (!rst_n)
        tape.req && !tape.gnt |=> tape.gnt)
        else $error("fetch request starved");

endmodule

/* reg_port.sv */
`timescale 1ns/1ps

module reg_port import tape_deck_pkg::*; #(
    parameter int ADDR_W = 21
) (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t reg_addr,
    input  logic      reg_rd,
    input  logic      reg_wr,
    input  logic [7:0] reg_wdata,
    output logic [7:0] reg_rdata,
    output logic      reg_ack,
    sram_bus_if.requester bus
);

    logic [ADDR_W-1:0] addr_q;
    logic              pend;     // Waiting for a grant
    logic              wait_rd;  // Read granted, data due
    logic              ack_q;
    logic              op_we, op_inc;
    logic [7:0]        wdata_q, rdata_q;
    logic              req_any, is_data, done;

    assign req_any = reg_rd || reg_wr;
    assign is_data = reg_addr == REG_SRAM_DATA || reg_addr == REG_SRAM_DATA_INC;
    assign done    = (bus.gnt && op_we) || bus.rvalid;

    assign bus.req   = pend;
    assign bus.we    = op_we;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign reg_rdata = rdata_q;
    assign reg_ack   = ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q  <= '0;
            pend    <= 1'b0;
            wait_rd <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= done;
            if (bus.gnt) begin
                pend    <= 1'b0;
                wait_rd <= !op_we;
            end
            if (bus.rvalid) begin
                wait_rd <= 1'b0;
            end
            if (done && op_inc) begin
                addr_q <= addr_q + 1'b1;  // Lands with the ack
            end
            if (req_any && is_data) begin
                pend <= 1'b1;
            end else if (req_any) begin
                ack_q <= 1'b1;
                if (reg_wr && reg_addr == REG_SRAM_ADDR) begin
                    addr_q <= {addr_q[ADDR_W-9:0], reg_wdata};  // New byte low
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_any && is_data) begin
            op_we   <= reg_wr;
            op_inc  <= reg_addr == REG_SRAM_DATA_INC;
            wdata_q <= reg_wdata;
        end
        if (bus.rvalid) begin
            rdata_q <= bus.rdata;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        req_any |-> !(pend || wait_rd))
        else $error("register request while an access is pending");

endmodule

/* pzx_fetch.sv */
`timescale 1ns/1ps

module pzx_fetch #(
    parameter int ADDR_W      = 21,
    parameter int FETCH_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    sram_bus_if.requester bus,
    pzx_stream_if.source  strm
);

    localparam int CNT_W = $clog2(FETCH_DEPTH + 1);
    localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;

    logic [ADDR_W-1:0] fptr;
    logic [CNT_W-1:0]  credits;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  drop_cnt;  // Stale reads still to come back
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [7:0]        fifo [FETCH_DEPTH];
    logic              push, refund;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FETCH_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Reads only, one per credit, quiet in reset
    assign bus.req   = rst_n && credits != '0;
    assign bus.we    = 1'b0;
    assign bus.addr  = fptr;
    assign bus.wdata = '0;

    assign refund = bus.rvalid && (strm.restart || drop_cnt != '0);
    assign push   = bus.rvalid && !refund;

    assign strm.valid = count != '0;
    assign strm.data  = fifo[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fptr     <= '0;
            credits  <= CNT_W'(FETCH_DEPTH);
            count    <= '0;
            drop_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else if (strm.restart) begin
            // A read granted now is still out, its credit comes back later
            fptr     <= strm.restart_addr;
            credits  <= CNT_W'(FETCH_DEPTH) - CNT_W'(bus.gnt);
            drop_cnt <= CNT_W'(bus.gnt);
            count    <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            if (bus.gnt) begin
                fptr <= fptr + 1'b1;
            end
            credits <= credits - CNT_W'(bus.gnt) + CNT_W'(strm.take) + CNT_W'(refund);
            if (refund) begin
                drop_cnt <= drop_cnt - 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(strm.take);
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (strm.take) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= bus.rdata;
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CNT_W'(FETCH_DEPTH))
        else $error("fetch credits above buffer depth");

endmodule

/* pzx_player.sv */
`timescale 1ns/1ps

module pzx_player import tape_deck_pkg::*; #(
    parameter int TSTATE_DIV = 8
) (
    input  logic clk,
    input  logic rst_n,
    pzx_stream_if.sink strm,
    input  logic play_in,
    input  logic stop_in,
    output logic pulse_out,
    output logic playing
);

    localparam int DIV_W = (TSTATE_DIV > 1) ? $clog2(TSTATE_DIV) : 1;

    player_state_e     state;
    logic              play_q, stop_q, play_edge, stop_edge;
    logic              restart_q, level;
    logic              step, take, rd_state, last_byte;
    logic              in_hold, tick_last, hold_done;
    logic [1:0]        nb, need_m1;  // Bytes taken in the current field
    logic [7:0]        tag_q;
    logic [31:0]       acc, acc_nx;
    logic [WORD_W-1:0] word_nx;
    dur_t              lblock, dur, tcnt;
    logic [14:0]       rep;
    logic [DIV_W-1:0]  tdiv;

    assign play_edge = play_in && !play_q;
    assign stop_edge = stop_in && !stop_q;
    assign step      = playing && !restart_q && !play_edge && !stop_edge;

    // Little-endian fields collect in the top of acc
    assign acc_nx  = {strm.data, acc[31:8]};
    assign word_nx = acc_nx[31:16];

    always_comb begin
        rd_state = 1'b0;
        need_m1  = 2'd0;
        case (state)
            ST_TAG:       rd_state = 1'b1;
            ST_SKIP:      rd_state = lblock != '0;
            ST_LEN, ST_PAUSE_DUR: begin
                rd_state = 1'b1;
                need_m1  = 2'd3;
            end
            ST_PULSE_W0, ST_PULSE_DUR, ST_PULSE_EXT: begin
                rd_state = state != ST_PULSE_W0 || lblock != '0;
                need_m1  = 2'd1;
            end
            default: ;
        endcase
    end

    assign last_byte = nb == need_m1;
    assign take      = step && rd_state && strm.valid;

    assign in_hold   = state == ST_PAUSE_HOLD || state == ST_PULSE_HOLD;
    assign tick_last = tdiv == DIV_W'(TSTATE_DIV - 1);
    assign hold_done = step && in_hold && tick_last && tcnt == dur - 1;

    assign strm.take         = take;
    assign strm.restart      = restart_q;
    assign strm.restart_addr = '0;
    assign pulse_out         = level;

    // ------------------------------------------------------------------------
    // Play control and block FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            playing   <= 1'b0;
            level     <= 1'b0;
            restart_q <= 1'b0;
            nb        <= 2'd0;
            play_q    <= 1'b0;
            stop_q    <= 1'b0;
        end else begin
            play_q    <= play_in;
            stop_q    <= stop_in;
            restart_q <= 1'b0;
            if (stop_edge) begin
                playing   <= 1'b0;
                state     <= ST_IDLE;
                restart_q <= 1'b1;
            end else if (play_edge) begin
                playing <= !playing;
                if (!playing && state == ST_IDLE) begin  // Rewind to address 0
                    restart_q <= 1'b1;
                    state     <= ST_TAG;
                    level     <= 1'b0;
                    nb        <= 2'd0;
                end
            end else if (step) begin
                if (take) begin
                    nb <= last_byte ? 2'd0 : nb + 2'd1;
                end
                case (state)
                    ST_TAG: if (take) state <= ST_LEN;
                    ST_LEN: begin
                        if (take && last_byte) begin
                            case (tag_q)
                                TAG_PULSE: begin
                                    level <= 1'b0;  // Every pulse block starts low
                                    state <= ST_PULSE_W0;
                                end
                                TAG_PAUSE: state <= ST_PAUSE_DUR;
                                TAG_STOP: begin
                                    playing <= 1'b0;  // Body is skipped on resume
                                    state   <= ST_SKIP;
                                end
                                default: begin
                                    playing   <= 1'b0;
                                    state     <= ST_IDLE;
                                    restart_q <= 1'b1;
                                end
                            endcase
                        end
                    end
                    ST_SKIP: if (lblock == '0) state <= ST_TAG;
                    ST_PAUSE_DUR: begin
                        if (take && last_byte) begin
                            level <= acc_nx[31];
                            state <= ST_PAUSE_HOLD;
                        end
                    end
                    ST_PAUSE_HOLD: if (dur == '0 || hold_done) state <= ST_TAG;
                    ST_PULSE_W0: begin
                        if (lblock == '0) begin
                            state <= ST_TAG;
                        end else if (take && last_byte) begin
                            state <= word_nx[15] ? ST_PULSE_DUR : ST_PULSE_HOLD;
                        end
                    end
                    ST_PULSE_DUR: begin
                        if (take && last_byte) begin
                            state <= word_nx[15] ? ST_PULSE_EXT : ST_PULSE_HOLD;
                        end
                    end
                    ST_PULSE_EXT: if (take && last_byte) state <= ST_PULSE_HOLD;
                    ST_PULSE_HOLD: begin
                        if (rep == '0) begin
                            state <= ST_PULSE_W0;
                        end else if (dur == '0) begin
                            level <= level ^ rep[0];  // Whole run at once
                        end else if (hold_done) begin
                            level <= !level;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // Field values
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            acc <= acc_nx;
        end
        if (step) begin
            case (state)
                ST_TAG: if (take) tag_q <= strm.data;
                ST_LEN: if (take && last_byte) lblock <= acc_nx;
                ST_SKIP, ST_PULSE_EXT: if (take) lblock <= lblock - 1'b1;
                ST_PAUSE_DUR: if (take && last_byte) dur <= {1'b0, acc_nx[30:0]};
                ST_PULSE_W0: begin
                    if (take) lblock <= lblock - 1'b1;
                    if (take && last_byte) begin
                        if (word_nx[15]) begin
                            rep <= word_nx[14:0];  // Repeat count, duration follows
                        end else begin
                            rep <= 15'd1;
                            dur <= {16'h0, word_nx};
                        end
                    end
                end
                ST_PULSE_DUR: begin
                    if (take) lblock <= lblock - 1'b1;
                    if (take && last_byte) begin
                        if (word_nx[15]) dur <= {1'b0, word_nx[14:0], 16'h0};
                        else dur <= {16'h0, word_nx};
                    end
                end
                ST_PULSE_HOLD: begin
                    if (rep != '0 && dur == '0) rep <= '0;
                    else if (hold_done) rep <= rep - 1'b1;
                end
                default: ;
            endcase
            if (state == ST_PULSE_EXT && take && last_byte) begin
                dur[15:0] <= word_nx;
            end
        end
    end

    // T-state divider and duration count, frozen while paused
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tdiv <= '0;
            tcnt <= '0;
        end else if (!in_hold || hold_done) begin
            tdiv <= '0;
            tcnt <= '0;
        end else if (step) begin
            if (tick_last) begin
                tdiv <= '0;
                tcnt <= tcnt + 1'b1;
            end else begin
                tdiv <= tdiv + 1'b1;
            end
        end
    end

endmodule

/* tape_deck.sv */
`timescale 1ns/1ps

module tape_deck import tape_deck_pkg::*; #(
    parameter int ADDR_W      = 21,
    parameter int FETCH_DEPTH = 4,
    parameter int TSTATE_DIV  = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  reg_addr_t  reg_addr,
    input  logic       reg_rd,
    input  logic       reg_wr,
    input  logic [7:0] reg_wdata,
    output logic [7:0] reg_rdata,
    output logic       reg_ack,
    input  logic       play_in,
    input  logic       stop_in,
    output logic       pulse_out,
    output logic       playing
);

    sram_bus_if   #(.ADDR_W(ADDR_W)) cpu_bus ();
    sram_bus_if   #(.ADDR_W(ADDR_W)) tape_bus ();
    sram_bus_if   #(.ADDR_W(ADDR_W)) mem_bus ();
    pzx_stream_if #(.ADDR_W(ADDR_W)) strm ();

    sram_store #(.ADDR_W(ADDR_W)) store_i (
        .clk,
        .mem (mem_bus)
    );

    sram_arbiter #(.ADDR_W(ADDR_W)) arb_i (
        .clk,
        .rst_n,
        .cpu  (cpu_bus),
        .tape (tape_bus),
        .mem  (mem_bus)
    );

    reg_port #(.ADDR_W(ADDR_W)) regs_i (
        .clk,
        .rst_n,
        .reg_addr,
        .reg_rd,
        .reg_wr,
        .reg_wdata,
        .reg_rdata,
        .reg_ack,
        .bus (cpu_bus)
    );

    pzx_fetch #(.ADDR_W(ADDR_W), .FETCH_DEPTH(FETCH_DEPTH)) fetch_i (
        .clk,
        .rst_n,
        .bus  (tape_bus),
        .strm (strm)
    );

    pzx_player #(.TSTATE_DIV(TSTATE_DIV)) player_i (
        .clk,
        .rst_n,
        .strm (strm),
        .play_in,
        .stop_in,
        .pulse_out,
        .playing
    );

endmodule

/* tb_pzx_model.svh */
`ifndef TB_PZX_MODEL_SVH
`define TB_PZX_MODEL_SVH

// ----------------------------------------------------------------------------
// Tape image and the pulse_out edges it should produce
// ----------------------------------------------------------------------------
logic [7:0]  img [$];
logic [7:0]  body [$];      // Body of the block being built
int          n_blocks;
int          exp_lvl [$];   // Level after each edge
int          exp_base [$];  // Exact hold clocks before the edge
int          exp_nb [$];    // Parse boundaries crossed before the edge
int          stop_idx;      // Edges before the stop block
int          hold_sum;
logic [31:0] lcg_state = 32'h5174_5740;

function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
endfunction

function automatic void put16(input logic [15:0] w);
    body.push_back(w[7:0]);
    body.push_back(w[15:8]);
endfunction

function automatic void put32(input logic [31:0] v);
    for (int i = 0; i < 4; i++) begin
        body.push_back(v[8*i +: 8]);
    end
endfunction

// Tag, little-endian length, then the collected body
function automatic void close_block(input logic [7:0] tag);
    logic [31:0] len;
    len = body.size();
    img.push_back(tag);
    for (int i = 0; i < 4; i++) begin
        img.push_back(len[8*i +: 8]);
    end
    foreach (body[i]) begin
        img.push_back(body[i]);
    end
    body.delete();
    n_blocks++;
endfunction

function automatic void build_image();
    put16(16'h8003);  // Run of 3 at 40
    put16(16'd40);
    put16(16'h8002);  // Run of 2 at 25
    put16(16'd25);
    put16(16'h8001);  // One pulse, 31-bit duration
    put16(16'h8001);
    put16(16'h0004);
    close_block(TAG_PULSE);
    put32({1'b1, 31'd50});
    close_block(TAG_PAUSE);
    close_block(TAG_STOP);
    put16(16'd30);
    put16(16'd30);
    close_block(TAG_PULSE);
    close_block(8'h00);  // Unknown tag ends the tape
endfunction

function automatic logic [31:0] img_le(input int pos, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = n - 1; i >= 0; i--) begin
        v = (v << 8) | img[pos + i];
    end
    return v;
endfunction

function automatic void add_edge(input logic lvl, input int base, input int nb);
    exp_lvl.push_back(lvl);
    exp_base.push_back(base);
    exp_nb.push_back(nb);
    hold_sum += base;
endfunction

// Walks the image the way the format defines it
function automatic void expected_edges();
    int          pos;
    int          blk_end;
    int          rep;
    int          base;
    int          nb;
    logic        lvl;
    logic [7:0]  tag;
    logic [31:0] w;
    logic [31:0] d;
    pos      = 0;
    lvl      = 1'b0;
    base     = 0;
    nb       = 1;  // Start of playback
    stop_idx = -1;
    while (pos < img.size()) begin
        tag     = img[pos];
        blk_end = pos + 5 + int'(img_le(pos + 1, 4));
        pos     = pos + 5;
        nb++;
        if (tag == TAG_PULSE) begin
            if (lvl) begin
                lvl = 1'b0;
                add_edge(lvl, base, nb);
                base = 0;
                nb   = 0;
            end
            while (pos < blk_end) begin
                w   = img_le(pos, 2);
                pos = pos + 2;
                rep = 1;
                if (w[15]) begin
                    rep = int'(w[14:0]);
                    w   = img_le(pos, 2);
                    pos = pos + 2;
                end
                d = w;
                if (w[15]) begin
                    d   = (32'(w[14:0]) << 16) | img_le(pos, 2);
                    pos = pos + 2;
                end
                nb++;
                repeat (rep) begin
                    base = base + int'(d) * TSTATE_DIV;
                    lvl  = !lvl;
                    add_edge(lvl, base, nb);
                    base = 0;
                    nb   = 0;
                end
            end
        end else if (tag == TAG_PAUSE) begin
            d   = img_le(pos, 4);
            pos = blk_end;
            nb++;
            if (d[31] != lvl) begin
                lvl = d[31];
                add_edge(lvl, base, nb);
                base = 0;
                nb   = 0;
            end
            base = base + int'(d[30:0]) * TSTATE_DIV;
        end else if (tag == TAG_STOP) begin
            pos      = blk_end;
            stop_idx = exp_lvl.size();
            base     = 0;  // Timing restarts at the resume
            nb       = 2;
        end else begin
            return;
        end
    end
endfunction

`endif

/* tb_tape_deck.sv */
`timescale 1ns/1ps

module tb_tape_deck import tape_deck_pkg::*; ();

    localparam int ADDR_W     = 12;
    localparam int TSTATE_DIV = 2;
    localparam int N_RT       = 16;  // Round trip bytes
    localparam int N_BG       = 8;   // Bytes per round during playback
    localparam int REG_OPS    = 2 * N_RT + 6 * N_BG + 40;

    logic       clk;
    logic       rst_n;
    reg_addr_t  reg_addr;
    logic       reg_rd, reg_wr;
    logic [7:0] reg_wdata, reg_rdata;
    logic       reg_ack;
    logic       play_in, stop_in;
    logic       pulse_out, playing;

    int   cyc = 0;
    int   ref_cyc = 0;   // Cycle of the last edge or play press
    int   idx = 0;       // Next expected edge
    int   edge_lim = 0;  // Edges allowed in the current phase
    int   slack = 12;    // Clocks per parse boundary
    int   limit = 0;
    int   gap;
    logic last_lvl = 1'b0;

    `include "tb_pzx_model.svh"

    tape_deck #(.ADDR_W(ADDR_W), .TSTATE_DIV(TSTATE_DIV)) dut_i (
        .clk, .rst_n, .reg_addr, .reg_rd, .reg_wr, .reg_wdata,
        .reg_rdata, .reg_ack, .play_in, .stop_in, .pulse_out, .playing
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = !clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input longint got, input longint exp);
        $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        abort_run();
    endtask

    task automatic fail_text(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // ------------------------------------------------------------------------
    // Register port access
    // ------------------------------------------------------------------------
    task automatic reg_access(input logic wr, input reg_addr_t addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int waits;
        reg_addr  = addr;
        reg_wdata = wdata;
        reg_wr    = wr;
        reg_rd    = !wr;
        @(posedge clk);
        #5;
        reg_wr = 1'b0;  // One-cycle request
        reg_rd = 1'b0;
        waits  = 0;
        while (!reg_ack) begin
            @(posedge clk);
            #5;
            waits = waits + 1;
        end
        if (addr == REG_SRAM_ADDR) begin  // Acks on the next cycle
            assert (waits == 0) else fail_value("reg_ack delay", waits, 0);
        end else begin
            assert (waits >= 1) else fail_value("reg_ack delay", waits, 1);
        end
        rdata = reg_rdata;
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [7:0] data);
        logic [7:0] unused;
        reg_access(1'b1, addr, data, unused);
    endtask

    task automatic set_addr(input int a);
        reg_write(REG_SRAM_ADDR, 8'(a >> 8));  // High byte shifts up
        reg_write(REG_SRAM_ADDR, 8'(a));
    endtask

    task automatic read_check(input reg_addr_t addr, input logic [7:0] exp);
        logic [7:0] got;
        reg_access(1'b0, addr, 8'h00, got);
        assert (got == exp) else fail_value("reg_rdata", got, exp);
    endtask

    task automatic round_trip(input int base, input int n);
        logic [7:0] data [$];
        logic [7:0] b;
        set_addr(base);
        repeat (n) begin
            b = lcg_byte();
            data.push_back(b);
            reg_write(REG_SRAM_DATA_INC, b);
        end
        set_addr(base);
        read_check(REG_SRAM_DATA, data[0]);  // Address must hold
        read_check(REG_SRAM_DATA, data[0]);
        foreach (data[i]) begin
            read_check(REG_SRAM_DATA_INC, data[i]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Play control
    // ------------------------------------------------------------------------
    task automatic press_play();
        play_in = 1'b1;
        ref_cyc = cyc;
        @(posedge clk);
        #5;
        play_in = 1'b0;
        @(posedge clk);
        #5;
        assert (playing) else fail_text("playing did not rise after play_in");
    endtask

    task automatic wait_stopped();
        while (playing) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic settle_check(input int n_edges);
        logic held;
        held = pulse_out;
        repeat (20) @(posedge clk);
        #5;
        assert (pulse_out == held) else fail_value("pulse_out", pulse_out, held);
        assert (idx == n_edges) else fail_value("edge count", idx, n_edges);
    endtask

    // Whole tape from address 0, through the stop block to the unknown tag
    task automatic full_pass();
        idx      = 0;
        edge_lim = stop_idx;
        press_play();
        wait_stopped();
        settle_check(stop_idx);
        edge_lim = exp_lvl.size();
        press_play();
        wait_stopped();
        settle_check(exp_lvl.size());
    endtask

    // Edge checker and run limit
    always @(posedge clk) begin
        cyc = cyc + 1;
        assert (limit == 0 || cyc <= limit) else fail_text("timeout, playback did not finish");
        if (rst_n && pulse_out !== last_lvl) begin
            gap = cyc - ref_cyc;
            assert (idx < edge_lim) else fail_text("pulse_out changed with no edge expected");
            assert (pulse_out == exp_lvl[idx])
                else fail_value("pulse_out", pulse_out, exp_lvl[idx]);
            assert (gap >= exp_base[idx] && gap <= exp_base[idx] + exp_nb[idx] * slack)
                else fail_value("edge interval", gap, exp_base[idx]);
            last_lvl = pulse_out;
            ref_cyc  = cyc;
            idx      = idx + 1;
        end
    end

    initial begin
        rst_n     = 1'b0;
        reg_addr  = '0;
        reg_rd    = 1'b0;
        reg_wr    = 1'b0;
        reg_wdata = '0;
        play_in   = 1'b0;
        stop_in   = 1'b0;
        build_image();
        expected_edges();
        limit = 3 * hold_sum + 200 * (3 * n_blocks + img.size() + REG_OPS);
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        round_trip(12'h900, N_RT);
        set_addr(0);
        foreach (img[i]) begin
            reg_write(REG_SRAM_DATA_INC, img[i]);
        end

        full_pass();

        // Stop in the middle of the first pulse block, level low
        idx      = 0;
        edge_lim = 2;
        press_play();
        while (idx < 2) begin
            @(posedge clk);
            #5;
        end
        stop_in = 1'b1;
        @(posedge clk);
        #5;
        stop_in = 1'b0;
        wait_stopped();
        settle_check(2);

        // Replay from 0 with register traffic alongside
        slack = 24;
        fork
            full_pass();
            repeat (3) round_trip(12'hA00, N_BG);
        join

        $display("all tests passed");
        $finish;
    end

endmodule

/* tape_deck.f */
+incdir+.
tape_deck_pkg.sv
sram_bus_if.sv
pzx_stream_if.sv
sram_store.sv
sram_arbiter.sv
reg_port.sv
pzx_fetch.sv
pzx_player.sv
tape_deck.sv
tb_tape_deck.sv
